// ==== source/rv_core_defs.svh ====
// ============================
// rv_core shared constants
// widths, fixed words and opcodes
// ============================
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// datapath sizing
`define RV_XLEN      32           // data and address width
`define RV_REG_COUNT 32           // architectural registers
`define RV_REG_AW    5            // register index width
`define RV_PC_STEP   4            // bytes per instruction

// fixed instruction words
`define RV_NOP  32'h0000_0013     // addi x0, x0, 0
`define RV_HALT 32'h0000_0073     // ecall

// ============================
// major opcodes
// ============================
`define RV_OP_REG    7'b0110011   // add sub and or slt sltu
`define RV_OP_IMM    7'b0010011   // addi
`define RV_OP_BRANCH 7'b1100011   // beq
`define RV_OP_JAL    7'b1101111   // jal
`define RV_OP_SYSTEM 7'b1110011   // ecall

`endif

// ==== source/rv_core_pkg.sv ====
// ============================
// rv_core types
// instruction views, alu ops, decoded controls
// ============================
`include "rv_core_defs.svh"

package rv_core_pkg;

    // register-register layout
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [2:0]             funct3;
        logic [`RV_REG_AW-1:0]  rd;
        logic [6:0]             opcode;
    } r_view_t;

    // immediate layout, imm12 overlays funct7 and rs2
    typedef struct packed {
        logic [11:0]            imm12;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [2:0]             funct3;
        logic [`RV_REG_AW-1:0]  rd;
        logic [6:0]             opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r;     // register fields
        i_view_t i;     // addi immediate
    } instr_u;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sltu
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;   // operand b from immediate
        logic    branch;    // beq, taken on zero
        logic    jump;      // jal
        logic    reg_wr;    // retires a register write
        logic    halt;      // ecall
    } ctrl_t;

    // bubble controls, what a NOP decodes to
    localparam ctrl_t ctrl_nop = '{alu_op: alu_add, default: 1'b0};

endpackage

// ==== source/rv_fwd_if.sv ====
// ============================
// rv_core forwarding bus
// mem and wb destinations back to decode/execute
// ============================
`timescale 1ns/1ps
`include "rv_core_defs.svh"

interface rv_fwd_if;

    // memory stage, one cycle behind execute
    logic                  mem_wr;
    logic [`RV_REG_AW-1:0] mem_rd;
    logic [`RV_XLEN-1:0]   mem_data;   // alu value or pc+4, already selected

    // writeback stage, also the register file write port
    logic                  wb_wr;
    logic [`RV_REG_AW-1:0] wb_rd;
    logic [`RV_XLEN-1:0]   wb_data;

    // execute owns both stage registers
    modport producer (
        output mem_wr, mem_rd, mem_data,
        output wb_wr, wb_rd, wb_data
    );

    // operand bypass in execute
    modport exec (
        input mem_wr, mem_rd, mem_data,
        input wb_wr, wb_rd, wb_data
    );

    // regfile write and write-through in decode
    modport dec (
        input wb_wr, wb_rd, wb_data
    );

endinterface

// ==== source/rv_fetch.sv ====
// ============================
// rv_core fetch stage
// pc, redirect, IF/ID register
// ============================
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                redirect,   // taken beq/jal from execute
    input  logic [`RV_XLEN-1:0] target,
    input  logic [`RV_XLEN-1:0] imem_data,  // combinational read of imem_addr
    output logic [`RV_XLEN-1:0] imem_addr,
    output rv_core_pkg::instr_u instr_d,
    output logic [`RV_XLEN-1:0] pc_d
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_next;
    logic [`RV_XLEN-1:0] instr_f;     // fetched word after flush

    // ============================
    // next pc
    // ============================
    assign pc_next = redirect ? target : pc + `RV_XLEN'(`RV_PC_STEP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;                 // program starts at address 0
        end else begin
            pc <= pc_next;
        end
    end

    assign imem_addr = pc;

    // the word fetched under a taken redirect is on the wrong path
    assign instr_f = redirect ? `RV_NOP : imem_data;

    // ============================
    // IF/ID register
    // ============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_d <= `RV_NOP;       // empty pipe decodes as bubble
        end else begin
            instr_d <= instr_f;
        end
    end

    // pc travels with its word into decode
    always_ff @(posedge clk) begin
        pc_d <= pc;
    end

endmodule

// ==== source/rv_decode.sv ====
// ============================
// rv_core decode stage
// control decode, register file, ID/EX register
// ============================
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_core_pkg::instr_u   instr_d,
    input  logic [`RV_XLEN-1:0]   pc_d,
    input  logic                  redirect,
    rv_fwd_if.dec                 fwd,
    output rv_core_pkg::ctrl_t    ctrl_e,
    output logic [`RV_XLEN-1:0]   rs1_val_e,
    output logic [`RV_XLEN-1:0]   rs2_val_e,
    output logic [`RV_XLEN-1:0]   imm_e,
    output logic [`RV_REG_AW-1:0] rd_e,
    output logic [`RV_REG_AW-1:0] rs1_e,
    output logic [`RV_REG_AW-1:0] rs2_e,
    output logic [`RV_XLEN-1:0]   pc_e
);

    rv_core_pkg::ctrl_t    ctrl;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_XLEN-1:0]   i_imm;
    logic [`RV_XLEN-1:0]   b_imm;
    logic [`RV_XLEN-1:0]   j_imm;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_XLEN-1:0]   rs1_val;
    logic [`RV_XLEN-1:0]   rs2_val;
    logic [`RV_XLEN-1:0]   rf [`RV_REG_COUNT];
    logic                  wb_live;   // wb write that targets a real register

    assign rs1 = instr_d.r.rs1;
    assign rs2 = instr_d.r.rs2;

    // ============================
    // immediates
    // ============================
    assign i_imm = {{20{instr_d.i.imm12[11]}}, instr_d.i.imm12};
    // B: imm[12|10:5] in funct7, imm[4:1|11] in the rd slot
    assign b_imm = {{20{instr_d.r.funct7[6]}}, instr_d.r.rd[0],
                    instr_d.r.funct7[5:0], instr_d.r.rd[4:1], 1'b0};
    // J: imm[20|10:1|11] in imm12, imm[19:12] in rs1 and funct3
    assign j_imm = {{12{instr_d.i.imm12[11]}}, instr_d.i.rs1, instr_d.i.funct3,
                    instr_d.i.imm12[0], instr_d.i.imm12[10:1], 1'b0};

    // direct decoder, anything unrecognized is a bubble
    always_comb begin
        ctrl = rv_core_pkg::ctrl_nop;
        imm  = '0;
        case (instr_d.r.opcode)
            `RV_OP_REG: begin
                ctrl.reg_wr = 1'b1;
                case ({instr_d.r.funct7, instr_d.r.funct3})
                    {7'h00, 3'b000}: ctrl.alu_op = rv_core_pkg::alu_add;
                    {7'h20, 3'b000}: ctrl.alu_op = rv_core_pkg::alu_sub;
                    {7'h00, 3'b111}: ctrl.alu_op = rv_core_pkg::alu_and;
                    {7'h00, 3'b110}: ctrl.alu_op = rv_core_pkg::alu_or;
                    {7'h00, 3'b010}: ctrl.alu_op = rv_core_pkg::alu_slt;
                    {7'h00, 3'b011}: ctrl.alu_op = rv_core_pkg::alu_sltu;
                    default:         ctrl = rv_core_pkg::ctrl_nop;   // mul family etc
                endcase
            end
            `RV_OP_IMM: begin
                if (instr_d.i.funct3 == 3'b000) begin   // addi only
                    ctrl.use_imm = 1'b1;
                    ctrl.reg_wr  = 1'b1;
                    imm          = i_imm;
                end
            end
            `RV_OP_BRANCH: begin
                if (instr_d.r.funct3 == 3'b000) begin   // beq, compare by subtract
                    ctrl.alu_op = rv_core_pkg::alu_sub;
                    ctrl.branch = 1'b1;
                    imm         = b_imm;
                end
            end
            `RV_OP_JAL: begin
                ctrl.jump   = 1'b1;
                ctrl.reg_wr = 1'b1;   // link value pc+4
                imm         = j_imm;
            end
            `RV_OP_SYSTEM: ctrl.halt = (instr_d == `RV_HALT);
            default: ;
        endcase
        if (instr_d.r.rd == '0) begin
            ctrl.reg_wr = 1'b0;       // x0 destination retires nothing
        end
    end

    // ============================
    // register file
    // ============================
    assign wb_live = fwd.wb_wr && (fwd.wb_rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < `RV_REG_COUNT; k++) begin
                rf[k] <= '0;
            end
        end else if (wb_live) begin
            rf[fwd.wb_rd] <= fwd.wb_data;
        end
    end

    // write-through, same-cycle wb result beats the stale entry
    assign rs1_val = (wb_live && fwd.wb_rd == rs1) ? fwd.wb_data : rf[rs1];
    assign rs2_val = (wb_live && fwd.wb_rd == rs2) ? fwd.wb_data : rf[rs2];

    // ============================
    // ID/EX register
    // ============================
    always_ff @(posedge clk) begin
        if (!rst_n || redirect) begin
            ctrl_e <= rv_core_pkg::ctrl_nop;   // squash wrong-path instruction
        end else begin
            ctrl_e <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        rs1_val_e <= rs1_val;
        rs2_val_e <= rs2_val;
        imm_e     <= imm;
        rd_e      <= instr_d.r.rd;
        rs1_e     <= rs1;
        rs2_e     <= rs2;
        pc_e      <= pc_d;
    end

endmodule

// ==== source/rv_execute.sv ====
// ============================
// rv_core execute, memory and writeback
// bypass, alu, redirect, EX/MEM and MEM/WB
// ============================
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_execute (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_core_pkg::ctrl_t    ctrl_e,
    input  logic [`RV_XLEN-1:0]   rs1_val_e,
    input  logic [`RV_XLEN-1:0]   rs2_val_e,
    input  logic [`RV_XLEN-1:0]   imm_e,
    input  logic [`RV_REG_AW-1:0] rd_e,
    input  logic [`RV_REG_AW-1:0] rs1_e,
    input  logic [`RV_REG_AW-1:0] rs2_e,
    input  logic [`RV_XLEN-1:0]   pc_e,
    output logic                  redirect,
    output logic [`RV_XLEN-1:0]   target,
    rv_fwd_if.producer            fwd,      // drives mem and wb stage state
    rv_fwd_if.exec                fwd_fb,   // same bus, read back for bypass
    output logic                  ohalt
);

    logic [`RV_XLEN-1:0]   op_a;
    logic [`RV_XLEN-1:0]   rs2_fwd;
    logic [`RV_XLEN-1:0]   op_b;
    logic [`RV_XLEN-1:0]   alu_res;
    logic [`RV_XLEN-1:0]   result_e;
    logic                  zero;

    // memory stage
    logic                  mem_wr;
    logic                  mem_halt;
    logic [`RV_REG_AW-1:0] mem_rd;
    logic [`RV_XLEN-1:0]   mem_data;

    // writeback stage
    logic                  wb_wr;
    logic                  wb_halt;
    logic [`RV_REG_AW-1:0] wb_rd;
    logic [`RV_XLEN-1:0]   wb_data;

    // a stage supplies src only if it really writes a nonzero rd
    function automatic logic fwd_hit(input logic wr,
                                     input logic [`RV_REG_AW-1:0] rd,
                                     input logic [`RV_REG_AW-1:0] src);
        return wr && (rd != '0) && (rd == src);
    endfunction

    // ============================
    // operand bypass
    // ============================
    always_comb begin
        if (fwd_hit(fwd_fb.mem_wr, fwd_fb.mem_rd, rs1_e)) begin
            op_a = fwd_fb.mem_data;             // distance 1, youngest wins
        end else if (fwd_hit(fwd_fb.wb_wr, fwd_fb.wb_rd, rs1_e)) begin
            op_a = fwd_fb.wb_data;              // distance 2
        end else begin
            op_a = rs1_val_e;
        end
        if (fwd_hit(fwd_fb.mem_wr, fwd_fb.mem_rd, rs2_e)) begin
            rs2_fwd = fwd_fb.mem_data;
        end else if (fwd_hit(fwd_fb.wb_wr, fwd_fb.wb_rd, rs2_e)) begin
            rs2_fwd = fwd_fb.wb_data;
        end else begin
            rs2_fwd = rs2_val_e;
        end
    end

    assign op_b = ctrl_e.use_imm ? imm_e : rs2_fwd;   // addi

    // ============================
    // alu and redirect
    // ============================
    always_comb begin
        unique case (ctrl_e.alu_op)
            rv_core_pkg::alu_add:  alu_res = op_a + op_b;
            rv_core_pkg::alu_sub:  alu_res = op_a - op_b;
            rv_core_pkg::alu_and:  alu_res = op_a & op_b;
            rv_core_pkg::alu_or:   alu_res = op_a | op_b;
            rv_core_pkg::alu_slt:  alu_res = `RV_XLEN'($signed(op_a) < $signed(op_b));
            rv_core_pkg::alu_sltu: alu_res = `RV_XLEN'(op_a < op_b);
            default:               alu_res = '0;
        endcase
    end

    assign zero     = (alu_res == '0);                      // beq: rs1 - rs2 == 0
    assign redirect = (ctrl_e.branch && zero) || ctrl_e.jump;
    assign target   = pc_e + imm_e;                         // pc-relative, beq and jal

    // writeback select, jal links pc+4
    assign result_e = ctrl_e.jump ? pc_e + `RV_XLEN'(`RV_PC_STEP) : alu_res;

    // ============================
    // EX/MEM and MEM/WB registers
    // ============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wr   <= 1'b0;
            mem_halt <= 1'b0;
            wb_wr    <= 1'b0;
            wb_halt  <= 1'b0;
        end else begin
            mem_wr   <= ctrl_e.reg_wr;
            mem_halt <= ctrl_e.halt;
            wb_wr    <= mem_wr;
            wb_halt  <= mem_halt;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd   <= rd_e;
        mem_data <= result_e;
        wb_rd    <= mem_rd;     // memory stage only passes through
        wb_data  <= mem_data;
    end

    assign fwd.mem_wr   = mem_wr;
    assign fwd.mem_rd   = mem_rd;
    assign fwd.mem_data = mem_data;
    assign fwd.wb_wr    = wb_wr;
    assign fwd.wb_rd    = wb_rd;
    assign fwd.wb_data  = wb_data;

    assign ohalt = wb_halt;     // ecall has reached writeback

endmodule

// ==== source/rv_core.sv ====
// ============================
// rv_core top
// five-stage RV32I subset, external imem
// ============================
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [`RV_XLEN-1:0]   imem_addr,
    input  logic [`RV_XLEN-1:0]   imem_data,   // same-cycle read
    output logic                  wb_en,       // retired result trace
    output logic [`RV_REG_AW-1:0] wb_rd,
    output logic [`RV_XLEN-1:0]   wb_data,
    output logic                  ohalt
);

    logic                  redirect;
    logic [`RV_XLEN-1:0]   target;
    rv_core_pkg::instr_u   instr_d;
    logic [`RV_XLEN-1:0]   pc_d;
    rv_core_pkg::ctrl_t    ctrl_e;
    logic [`RV_XLEN-1:0]   rs1_val_e;
    logic [`RV_XLEN-1:0]   rs2_val_e;
    logic [`RV_XLEN-1:0]   imm_e;
    logic [`RV_REG_AW-1:0] rd_e;
    logic [`RV_REG_AW-1:0] rs1_e;
    logic [`RV_REG_AW-1:0] rs2_e;
    logic [`RV_XLEN-1:0]   pc_e;

    rv_fwd_if fwd ();

    rv_fetch u_fetch (
        .clk, .rst_n, .redirect, .target, .imem_data,
        .imem_addr, .instr_d, .pc_d
    );

    rv_decode u_decode (
        .clk, .rst_n, .instr_d, .pc_d, .redirect,
        .fwd       (fwd.dec),
        .ctrl_e, .rs1_val_e, .rs2_val_e, .imm_e, .rd_e, .rs1_e, .rs2_e, .pc_e
    );

    rv_execute u_execute (
        .clk, .rst_n,
        .ctrl_e, .rs1_val_e, .rs2_val_e, .imm_e, .rd_e, .rs1_e, .rs2_e, .pc_e,
        .redirect, .target,
        .fwd       (fwd.producer),
        .fwd_fb    (fwd.exec),
        .ohalt
    );

    // trace taps the register file write port
    assign wb_en   = fwd.wb_wr;
    assign wb_rd   = fwd.wb_rd;
    assign wb_data = fwd.wb_data;

endmodule

// ==== testbench/tb_rv_core_sva.sv ====
// ============================
// rv_core trace assertions
// bound into the core top level
// ============================
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module tb_rv_core_sva (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  wb_en,
    input logic [`RV_REG_AW-1:0] wb_rd,
    input logic                  ohalt
);

    // retired writes never name x0
    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> (wb_rd != '0))
        else $error("retired write with rd x0");

    // halt is a single-cycle pulse
    halt_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        ohalt |=> !ohalt)
        else $error("ohalt held longer than one cycle");

    // ecall never carries a register write
    no_wb_on_halt: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_en && ohalt))
        else $error("wb_en and ohalt high together");

endmodule

bind rv_core tb_rv_core_sva i_sva (
    .clk   (clk),
    .rst_n (rst_n),
    .wb_en (wb_en),
    .wb_rd (wb_rd),
    .ohalt (ohalt)
);

// ==== testbench/tb_rv_core.sv ====
// ============================
// rv_core testbench
// random programs, ISA reference model, trace compare
// ============================
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module tb_rv_core;

    localparam int CLK_PERIOD      = 10;
    localparam int DRV_DLY         = 1;     // input drive after rising edge
    localparam int RST_CYCLES      = 16;
    localparam int PROG_WORDS      = 64;
    localparam int HALT_IDX        = 56;    // ecall slot with NOPs after it
    localparam int SEED_REGS       = 6;     // leading addi to x1..x6
    localparam int NUM_PROGRAMS    = 4;
    localparam int DRAIN_CYCLES    = 4;
    localparam int WATCHDOG_CYCLES = 2 * NUM_PROGRAMS * (PROG_WORDS + 20);

    logic                  clk;
    logic                  rst_n;
    logic [`RV_XLEN-1:0]   imem_addr;
    logic [`RV_XLEN-1:0]   imem_data;
    logic                  wb_en;
    logic [`RV_REG_AW-1:0] wb_rd;
    logic [`RV_XLEN-1:0]   wb_data;
    logic                  ohalt;

    logic [`RV_XLEN-1:0]   prog [PROG_WORDS];   // instruction memory contents
    logic [`RV_REG_AW-1:0] exp_rd [$];          // expected retire order
    logic [`RV_XLEN-1:0]   exp_data [$];
    int                    exp_idx;
    int                    halt_count;
    integer                seed;

    rv_core i_dut (
        .clk, .rst_n, .imem_addr, .imem_data,
        .wb_en, .wb_rd, .wb_data, .ohalt
    );

    // combinational imem read with NOP past the array
    assign imem_data = (imem_addr < PROG_WORDS * 4) ? prog[imem_addr[7:2]] : `RV_NOP;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // ============================
    // instruction encoders
    // ============================
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        rv_core_pkg::instr_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = `RV_OP_REG;
        return w;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd);
        rv_core_pkg::instr_u w;
        w.i.imm12  = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = 3'b000;     // addi
        w.i.rd     = rd;
        w.i.opcode = `RV_OP_IMM;
        return w;
    endfunction

    // beq with a byte offset
    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    // ============================
    // program generation
    // ============================
    function automatic void gen_program();
        logic [31:0] rnd;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          k;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = `RV_NOP;
        end
        for (int i = 0; i < SEED_REGS; i++) begin
            rnd     = $random(seed);
            prog[i] = enc_i(rnd[11:0], 5'd0, 5'(i + 1));   // mixed-sign start values
        end
        for (int i = SEED_REGS; i < HALT_IDX; i++) begin
            rnd = $random(seed);
            rd  = {2'b00, rnd[6:4]};      // x0..x7 for dense dependencies
            rs1 = {2'b00, rnd[9:7]};
            rs2 = {2'b00, rnd[12:10]};
            k   = 1 + int'(rnd[15:13]);   // forward skip in words
            if (i + k > HALT_IDX) begin
                k = HALT_IDX - i;         // never past the ecall
            end
            case (rnd[3:0])
                4'd8, 4'd9, 4'd10: prog[i] = enc_i(rnd[27:16], rs1, rd);
                4'd11, 4'd12, 4'd13: begin
                    if (rnd[28]) begin
                        rs2 = rs1;        // forces a taken beq
                    end
                    prog[i] = enc_b(13'(k * 4), rs1, rs2);
                end
                4'd14: prog[i] = enc_j(21'(k * 4), rd);
                default: begin
                    case (rnd[31:29])
                        3'd0:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd);   // add
                        3'd1:       prog[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd);   // sub
                        3'd2:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b111, rd);   // and
                        3'd3:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd);   // or
                        3'd4, 3'd6: prog[i] = enc_r(7'h00, rs2, rs1, 3'b010, rd);   // slt
                        default:    prog[i] = enc_r(7'h00, rs2, rs1, 3'b011, rd);   // sltu
                    endcase
                end
            endcase
        end
        prog[HALT_IDX] = `RV_HALT;
    endfunction

    // ============================
    // ISA reference model
    // ============================
    function automatic void ref_run();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] nxt;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        wr;
        exp_rd.delete();
        exp_data.delete();
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc = '0;
        for (int step = 0; step < 4 * PROG_WORDS; step++) begin
            w = prog[pc[7:2]];
            if (w == `RV_HALT) break;
            a   = regs[w[19:15]];
            b   = regs[w[24:20]];
            res = '0;
            wr  = 1'b0;
            nxt = pc + 32'd4;
            case (w[6:0])
                `RV_OP_REG: begin
                    wr = 1'b1;
                    case ({w[31:25], w[14:12]})
                        {7'h00, 3'b000}: res = a + b;
                        {7'h20, 3'b000}: res = a - b;
                        {7'h00, 3'b111}: res = a & b;
                        {7'h00, 3'b110}: res = a | b;
                        {7'h00, 3'b010}: res = {31'b0, $signed(a) < $signed(b)};
                        {7'h00, 3'b011}: res = {31'b0, a < b};
                        default:         wr  = 1'b0;
                    endcase
                end
                `RV_OP_IMM: begin
                    wr  = 1'b1;
                    res = a + {{20{w[31]}}, w[31:20]};
                end
                `RV_OP_BRANCH: begin
                    if (a == b) begin
                        nxt = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                `RV_OP_JAL: begin
                    wr  = 1'b1;
                    res = pc + 32'd4;     // link address
                    nxt = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                default: ;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                regs[w[11:7]] = res;      // x0 stays zero
                exp_rd.push_back(w[11:7]);
                exp_data.push_back(res);
            end
            pc = nxt;
        end
    endfunction

    // ============================
    // trace compare sampled mid-cycle
    // ============================
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!wb_en && !ohalt) else fail_now("wb_en or ohalt high while in reset");
        end else begin
            assert (!(wb_en && ohalt)) else fail_now("wb_en and ohalt high in the same cycle");
            if (wb_en) begin
                assert (exp_idx < exp_rd.size())
                    else fail_now("writeback seen after all expected writes retired");
                assert (wb_rd != '0) else fail_now("write to x0 reached the trace port");
                assert (wb_rd == exp_rd[exp_idx])
                    else fail_now($sformatf("mismatch at %0t: wb_rd got %0d expected %0d",
                                            $time, wb_rd, exp_rd[exp_idx]));
                assert (wb_data == exp_data[exp_idx])
                    else fail_now($sformatf("mismatch at %0t: wb_data got %h expected %h",
                                            $time, wb_data, exp_data[exp_idx]));
                exp_idx++;
            end
            if (ohalt) begin
                assert (halt_count == 0) else fail_now("ohalt pulsed more than once");
                assert (exp_idx == exp_rd.size())
                    else fail_now($sformatf("mismatch at %0t: write count got %0d expected %0d",
                                            $time, exp_idx, exp_rd.size()));
                halt_count++;
            end
        end
    end

    // one program through reset, load, run to halt and drain
    task automatic run_program(input int num);
        @(posedge clk);
        #DRV_DLY rst_n = 1'b0;
        gen_program();             // next reset edge discards anything fetched
        ref_run();
        exp_idx    = 0;
        halt_count = 0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRV_DLY rst_n = 1'b1;
        @(negedge clk);
        assert (imem_addr == '0)
            else fail_now($sformatf("mismatch at %0t: imem_addr got %h expected %h",
                                    $time, imem_addr, 32'h0));
        while (halt_count == 0) begin
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);   // NOPs behind the halt retire
        $display("program %0d: %0d writes retired", num, exp_idx);
    endtask

    initial begin
        seed       = 36;
        exp_idx    = 0;
        halt_count = 0;
        rst_n      = 1'b0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = `RV_NOP;
        end
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            run_program(p);
        end
        $display("TESTS PASSED");
        $finish;
    end

    // watchdog at twice the nominal run length
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: halt not reached within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== rv_core.f ====
+incdir+source
source/rv_core_pkg.sv
source/rv_fwd_if.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_core.sv
testbench/tb_rv_core_sva.sv
testbench/tb_rv_core.sv

// ==== Makefile ====
# Verilator build and run for rv_core

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= rv_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# exit status is nonzero when the testbench fails
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
